/* sim.f */
rtl/gpe_pkg.sv
rtl/gpe_op_if.sv
rtl/gpe_trig_arb.sv
rtl/gpe_cmd_seq.sv
rtl/gpe_bus_exec.sv
rtl/gpe_top.sv
dv/tb_gpe_top.sv

/* Makefile */
# Verilator simulation of the GP engine

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_gpe_top -f sim.f -Mdir obj_dir
	./obj_dir/Vtb_gpe_top | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* dv/tb_gpe_top.sv */
////////////////////
// GP engine testbench
// Random programs checked against a model and a scripted bus slave
////////////////////
`timescale 1ns/1ps

module tb_gpe_top;
    import gpe_pkg::*;

    localparam logic [31:0] SEED      = 32'h68879691;
    localparam int          NUM_RAND  = 10;      // Single-source random tests
    localparam int          NUM_TESTS = NUM_RAND + 3;
    localparam int          MAX_CMDS  = 6;
    localparam int          MAX_DLY   = 3;       // Back-pressure cycles
    localparam int          MAX_K     = 3;       // Failing reads per poll
    localparam logic [29:0] WORD_BASE = 30'h100;
    localparam int CMD_CYC      = MAX_DLY + 6 + (MAX_K + 1) * (2 * MAX_DLY + 4);
    localparam int TEST_CYC     = N_TRIG * (MAX_CMDS + 1) * CMD_CYC + 60;
    localparam int WATCHDOG_CYC = NUM_TESTS * TEST_CYC;

    logic      i_clk;
    logic      i_rstn;
    trig_vec_t i_trig;
    trig_vec_t i_trig_en;
    trig_vec_t i_trig_rise;
    cmd_addr_t i_trig_start [N_TRIG];
    logic      o_cmd_rd_en;
    cmd_addr_t o_cmd_addr;
    cmd_word_t i_cmd_data   = '0;
    logic      i_cmd_valid  = 1'b0;
    logic      o_busy;
    logic      o_bus_valid;
    logic      o_bus_write;
    bus_addr_t o_bus_addr;
    data_t     o_bus_wdata;
    logic      i_bus_ready  = 1'b0;
    data_t     i_bus_rdata  = '0;
    logic      i_bus_rvalid = 1'b0;

    cmd_word_t cmd_mem [2**CMD_ADDR_W];          // Command buffer
    data_t     bus_mem [16];                     // Model copy of bus memory
    logic      exp_write [$];
    bus_addr_t exp_addr [$];
    data_t     exp_data [$];                     // Write data or read response
    cmd_addr_t exp_cmd [$];
    int        exp_cmd_txn [$];                  // Bus transfers before each fetch
    int        txn_total  = 0;
    int        txn_count  = 0;
    logic      model_rmw  = 1'b0;
    data_t     rmw_keep;
    data_t     rmw_mask;
    int        cmd_wait   = 0;
    int        rdy_wait   = 0;
    int        rd_wait    = 0;
    logic      rd_pend    = 1'b0;
    data_t     rd_val;
    int        prog_seed;
    int        bp_seed;
    string     cur_test   = "init";
    int        test_err   = 0;
    int        err_total  = 0;
    int        fail_tests = 0;

    gpe_top DUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_CYC * 20);
        $display("Timeout in %s, the engine stopped making progress", cur_test);
        $display("Verification failed");
        $finish;
    end

    function automatic int prog_rand(input int n);
        return int'($unsigned($random(prog_seed)) % n);
    endfunction

    function automatic int bp_rand(input int n);
        return int'($unsigned($random(bp_seed)) % n);
    endfunction

    function automatic data_t low_bit(input data_t d);
        return d & (~d + data_t'(1));            // Lowest set bit of the mask
    endfunction

    ////////////////////
    // Checks
    ////////////////////
    task automatic compare_data(input string what, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("ERR %s: %s expected %h actual %h", cur_test, what, exp, act);
            test_err++;
        end
    endtask

    task automatic compare_addr(input string what, input bus_addr_t exp, input bus_addr_t act);
        if (act !== exp) begin
            $display("ERR %s: %s expected %h actual %h", cur_test, what, exp, act);
            test_err++;
        end
    endtask

    task automatic compare_cmd_addr(input string what, input cmd_addr_t exp,
                                    input cmd_addr_t act);
        if (act !== exp) begin
            $display("ERR %s: %s expected %h actual %h", cur_test, what, exp, act);
            test_err++;
        end
    endtask

    task automatic compare_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %s: %s expected %0d actual %0d", cur_test, what, exp, act);
            test_err++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("Error in %s: %s", cur_test, what);
        test_err++;
    endtask

    task automatic finish_test();
        $display("%-18s %s, %0d errors", cur_test, (test_err == 0) ? "ok" : "FAILED", test_err);
        err_total += test_err;
        if (test_err != 0) begin
            fail_tests++;
        end
        test_err = 0;
    endtask

    ////////////////////
    // Programs and model
    ////////////////////
    task automatic gen_program(input int src);
        cmd_addr_t ca;
        int        kind;
        int        prev;
        data_t     d;
        ca   = i_trig_start[trig_idx_t'(src)];
        prev = -1;
        repeat (1 + prog_rand(MAX_CMDS)) begin
            // An RMW read always gets its write next
            kind = (prev == int'(OP_RMW_READ)) ? int'(OP_WRITE) : prog_rand(4);
            d    = data_t'($random(prog_seed));
            if (d == '0) begin
                d = data_t'(1);                  // Masks need one bit at least
            end
            cmd_mem[ca] = {kind[1:0], WORD_BASE + 30'(prog_rand(16)), d};
            prev = kind;
            ca   = ca + CMD_ADDR_STEP;
        end
        cmd_mem[ca] = '0;                        // End of sequence
    endtask

    task automatic push_txn(input logic w, input bus_addr_t a, input data_t d);
        exp_write.push_back(w);
        exp_addr.push_back(a);
        exp_data.push_back(d);
        txn_total++;
    endtask

    task automatic run_model(input int src);
        cmd_addr_t  ca;
        cmd_word_t  w;
        bus_addr_t  a;
        data_t      d;
        data_t      v;
        logic [3:0] idx;
        int         k;
        logic       done;
        ca   = i_trig_start[trig_idx_t'(src)];
        done = 1'b0;
        while (!done) begin
            w = cmd_mem[ca];
            exp_cmd.push_back(ca);
            exp_cmd_txn.push_back(txn_total);
            if (w == '0) begin
                done = 1'b1;
            end else begin
                a   = {w[CADDR_MSB:CADDR_LSB], 2'b00};
                d   = w[CDATA_MSB:0];
                idx = a[5:2];
                k   = prog_rand(MAX_K + 1);
                case (opcode_e'(w[OPC_MSB:OPC_LSB]))
                    OP_WRITE: begin
                        v = model_rmw ? (rmw_keep | (d & rmw_mask)) : d;
                        model_rmw    = 1'b0;
                        bus_mem[idx] = v;
                        push_txn(1'b1, a, v);
                    end
                    OP_RMW_READ: begin
                        push_txn(1'b0, a, bus_mem[idx]);
                        rmw_keep  = bus_mem[idx] & ~d;
                        rmw_mask  = d;
                        model_rmw = 1'b1;
                    end
                    OP_POLL_SET: begin
                        repeat (k) push_txn(1'b0, a, data_t'($random(prog_seed)) & ~low_bit(d));
                        push_txn(1'b0, a, data_t'($random(prog_seed)) | d);
                    end
                    default: begin               // Poll until masked bits clear
                        repeat (k) push_txn(1'b0, a, data_t'($random(prog_seed)) | low_bit(d));
                        push_txn(1'b0, a, data_t'($random(prog_seed)) & ~d);
                    end
                endcase
                ca = ca + CMD_ADDR_STEP;
            end
        end
    endtask

    ////////////////////
    // Command buffer and bus slave
    ////////////////////
    task automatic serve_cmd();
        if (exp_cmd.size() == 0) begin
            note_failure("command read started with no trigger expected");
        end else begin
            compare_cmd_addr("command address", exp_cmd.pop_front(), o_cmd_addr);
            compare_count("bus transfers before fetch", exp_cmd_txn.pop_front(), txn_count);
        end
        i_cmd_data  = cmd_mem[o_cmd_addr];
        i_cmd_valid = 1'b1;
    endtask

    task automatic accept_bus();
        logic  w;
        data_t d;
        txn_count++;
        d = '0;
        if (exp_addr.size() == 0) begin
            note_failure("bus transfer with none expected");
        end else begin
            w = exp_write.pop_front();
            d = exp_data.pop_front();
            compare_addr("bus address", exp_addr.pop_front(), o_bus_addr);
            if (w !== o_bus_write) begin
                note_failure("bus direction differs from the model");
            end else if (w) begin
                compare_data("write data", d, o_bus_wdata);
            end
        end
        if (!o_bus_write) begin
            rd_pend = 1'b1;
            rd_val  = d;
            rd_wait = bp_rand(MAX_DLY + 1);
        end
    endtask

    always @(negedge i_clk) begin
        if (i_rstn) begin
            if (i_cmd_valid) begin
                i_cmd_valid = 1'b0;              // Word taken on the last edge
            end else if (o_cmd_rd_en) begin
                if (cmd_wait > 0) begin
                    cmd_wait--;
                end else begin
                    serve_cmd();
                    cmd_wait = bp_rand(MAX_DLY + 1);
                end
            end
            if (i_bus_rvalid) begin
                i_bus_rvalid = 1'b0;
            end else if (rd_pend) begin
                if (rd_wait > 0) begin
                    rd_wait--;
                end else begin
                    i_bus_rvalid = 1'b1;
                    i_bus_rdata  = rd_val;
                    rd_pend      = 1'b0;
                end
            end
            if (i_bus_ready) begin
                i_bus_ready = 1'b0;
            end else if (o_bus_valid) begin
                if (rdy_wait > 0) begin
                    rdy_wait--;
                end else begin
                    i_bus_ready = 1'b1;          // Accept lands on the next edge
                    accept_bus();
                    rdy_wait = bp_rand(MAX_DLY + 1);
                end
            end
        end
    end

    task automatic pulse_trig(input trig_vec_t m);
        i_trig = i_trig | m;
        repeat (2) @(negedge i_clk);
        i_trig = i_trig & ~m;
    endtask

    task automatic wait_done();
        @(negedge i_clk);
        while (exp_cmd.size() != 0 || exp_addr.size() != 0 || o_busy) begin
            @(negedge i_clk);
        end
        repeat (10) @(negedge i_clk);            // Nothing further may start
    endtask

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        int src;
        prog_seed   = int'(SEED);
        bp_seed     = int'(SEED);
        i_rstn      = 1'b0;
        i_trig      = '0;
        i_trig_en   = '0;
        i_trig_rise = '0;
        for (int i = 0; i < N_TRIG; i++) begin
            i_trig_start[trig_idx_t'(i)] = cmd_addr_t'(i * 64);
        end
        for (int i = 0; i < 16; i++) begin
            bus_mem[i] = data_t'($random(prog_seed));
        end
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_rstn = 1'b1;

        cur_test = "reset_idle";
        if (o_cmd_rd_en || o_bus_valid || o_busy) begin
            note_failure("outputs not idle after reset");
        end
        i_trig_en   = '1;
        i_trig_rise = '1;
        repeat (20) @(negedge i_clk);
        finish_test();

        for (int t = 0; t < NUM_RAND; t++) begin
            cur_test = $sformatf("random_prog_%0d", t);
            src      = prog_rand(N_TRIG);
            gen_program(src);
            run_model(src);
            pulse_trig(trig_vec_t'(1 << src));
            wait_done();
            finish_test();
        end

        cur_test    = "fall_and_disable";
        i_trig_en   = 4'b1101;                   // Source 1 disabled
        i_trig_rise = 4'b1011;                   // Source 2 fires on a fall
        gen_program(1);
        gen_program(2);
        i_trig = 4'b0110;
        repeat (12) @(negedge i_clk);
        run_model(2);
        i_trig = 4'b0000;
        wait_done();
        finish_test();

        cur_test    = "multi_source";
        i_trig_en   = '1;
        i_trig_rise = '1;
        for (int s = 0; s < N_TRIG; s++) begin
            gen_program(s);
        end
        run_model(3);
        pulse_trig(4'b1000);
        while (!o_busy) begin
            @(negedge i_clk);
        end
        for (int s = 0; s < 3; s++) begin
            run_model(s);
        end
        pulse_trig(4'b0111);                     // Edges while source 3 runs
        wait_done();
        finish_test();

        $display("Tests %0d, failing tests %0d, errors %0d", NUM_TESTS, fail_tests, err_total);
        if (err_total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* rtl/gpe_top.sv */
////////////////////
// GP engine top level
// Trigger arbiter, command sequencer and bus executor
////////////////////
`timescale 1ns/1ps

module gpe_top (
    input  logic               i_clk,
    input  logic               i_rstn,

    // Trigger sources and their setup
    input  gpe_pkg::trig_vec_t i_trig,
    input  gpe_pkg::trig_vec_t i_trig_en,
    input  gpe_pkg::trig_vec_t i_trig_rise,
    input  gpe_pkg::cmd_addr_t i_trig_start [gpe_pkg::N_TRIG],

    // Command buffer
    output logic               o_cmd_rd_en,
    output gpe_pkg::cmd_addr_t o_cmd_addr,
    input  gpe_pkg::cmd_word_t i_cmd_data,
    input  logic               i_cmd_valid,
    output logic               o_busy,

    // Bus master port
    output logic               o_bus_valid,
    output logic               o_bus_write,
    output gpe_pkg::bus_addr_t o_bus_addr,
    output gpe_pkg::data_t     o_bus_wdata,
    input  logic               i_bus_ready,
    input  gpe_pkg::data_t     i_bus_rdata,
    input  logic               i_bus_rvalid
);
    import gpe_pkg::*;

    logic      trig_req;
    logic      trig_ack;
    cmd_addr_t trig_start;                       // Start address of the chosen source

    gpe_op_if op_if ();

    gpe_trig_arb u_trig_arb (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_trig       (i_trig),
        .i_trig_en    (i_trig_en),
        .i_trig_rise  (i_trig_rise),
        .i_trig_start (i_trig_start),
        .o_req        (trig_req),
        .i_ack        (trig_ack),
        .o_start      (trig_start)
    );

    gpe_cmd_seq u_cmd_seq (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_trig_req   (trig_req),
        .o_trig_ack   (trig_ack),
        .i_trig_start (trig_start),
        .o_cmd_rd_en  (o_cmd_rd_en),
        .o_cmd_addr   (o_cmd_addr),
        .i_cmd_data   (i_cmd_data),
        .i_cmd_valid  (i_cmd_valid),
        .o_busy       (o_busy),
        .op           (op_if.seq)
    );

    gpe_bus_exec u_bus_exec (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .op           (op_if.exec),
        .o_bus_valid  (o_bus_valid),
        .o_bus_write  (o_bus_write),
        .o_bus_addr   (o_bus_addr),
        .o_bus_wdata  (o_bus_wdata),
        .i_bus_ready  (i_bus_ready),
        .i_bus_rdata  (i_bus_rdata),
        .i_bus_rvalid (i_bus_rvalid)
    );

endmodule

/* rtl/gpe_bus_exec.sv */
////////////////////
// GP engine bus executor
// Runs write, RMW read and poll operations on the bus master port
////////////////////
`timescale 1ns/1ps

module gpe_bus_exec (
    input  logic               i_clk,
    input  logic               i_rstn,
    gpe_op_if.exec             op,
    output logic               o_bus_valid,
    output logic               o_bus_write,
    output gpe_pkg::bus_addr_t o_bus_addr,
    output gpe_pkg::data_t     o_bus_wdata,
    input  logic               i_bus_ready,
    input  gpe_pkg::data_t     i_bus_rdata,
    input  logic               i_bus_rvalid
);
    import gpe_pkg::*;

    exec_state_e state;
    logic        rmw_pend;                       // Kept value waits for a write
    data_t       rmw_keep;                       // Read data with mask bits cleared
    data_t       rmw_mask;
    data_t       masked_rd;
    data_t       wr_data;
    logic        is_write;
    logic        op_start;
    logic        rd_done;
    logic        rd_pass;

    assign is_write  = (op.op_kind == OP_WRITE);
    assign op_start  = (state == EX_IDLE) && op.op_req && !op.op_ack;
    assign rd_done   = (state == EX_RDATA) && i_bus_rvalid;
    assign masked_rd = i_bus_rdata & op.op_data;

    always_comb begin
        case (op.op_kind)
            OP_POLL_SET: rd_pass = (masked_rd == op.op_data);
            OP_POLL_CLR: rd_pass = (masked_rd == '0);
            default:     rd_pass = 1'b1;         // RMW read takes one read
        endcase
    end

    always_comb begin
        if (!is_write) begin
            wr_data = '0;
        end else if (rmw_pend) begin
            wr_data = rmw_keep | (op.op_data & rmw_mask);  // Merge into kept value
        end else begin
            wr_data = op.op_data;
        end
    end

    ////////////////////
    // Executor FSM
    ////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state       <= EX_IDLE;
            o_bus_valid <= 1'b0;
            op.op_ack   <= 1'b0;
            rmw_pend    <= 1'b0;
        end else begin
            case (state)
                EX_IDLE: begin
                    if (op_start) begin
                        o_bus_valid <= 1'b1;
                        state       <= EX_ADDR;
                    end
                end
                EX_ADDR: begin
                    if (i_bus_ready) begin
                        o_bus_valid <= 1'b0;
                        if (o_bus_write) begin
                            op.op_ack <= 1'b1;   // Write done on accept
                            rmw_pend  <= 1'b0;
                            state     <= EX_ACK;
                        end else begin
                            state <= EX_RDATA;
                        end
                    end
                end
                EX_RDATA: begin
                    if (i_bus_rvalid) begin
                        if (rd_pass) begin
                            op.op_ack <= 1'b1;
                            state     <= EX_ACK;
                            if (op.op_kind == OP_RMW_READ) begin
                                rmw_pend <= 1'b1;
                            end
                        end else begin
                            o_bus_valid <= 1'b1; // Poll again with the same request
                            state       <= EX_ADDR;
                        end
                    end
                end
                EX_ACK: begin
                    if (!op.op_req) begin
                        op.op_ack <= 1'b0;
                        state     <= EX_IDLE;
                    end
                end
                default: begin
                    state <= EX_IDLE;
                end
            endcase
        end
    end

    // Bus request fields and RMW store
    always_ff @(posedge i_clk) begin
        if (op_start) begin
            o_bus_write <= is_write;
            o_bus_addr  <= op.op_addr;
            o_bus_wdata <= wr_data;
        end
        if (rd_done && (op.op_kind == OP_RMW_READ)) begin
            rmw_keep <= i_bus_rdata & ~op.op_data;
            rmw_mask <= op.op_data;
        end
    end

endmodule

/* rtl/gpe_cmd_seq.sv */
////////////////////
// GP engine command sequencer
// Fetches and decodes command words and issues bus operations
////////////////////
`timescale 1ns/1ps

module gpe_cmd_seq (
    input  logic               i_clk,
    input  logic               i_rstn,
    input  logic               i_trig_req,
    output logic               o_trig_ack,
    input  gpe_pkg::cmd_addr_t i_trig_start,
    output logic               o_cmd_rd_en,
    output gpe_pkg::cmd_addr_t o_cmd_addr,
    input  gpe_pkg::cmd_word_t i_cmd_data,
    input  logic               i_cmd_valid,
    output logic               o_busy,
    gpe_op_if.seq              op
);
    import gpe_pkg::*;

    seq_state_e state;
    logic       word_take;                       // Command word arrives this cycle
    logic       word_zero;                       // End of sequence marker

    assign word_take = (state == SEQ_FETCH) && o_cmd_rd_en && i_cmd_valid;
    assign word_zero = (i_cmd_data == '0);
    assign o_busy    = (state != SEQ_IDLE);

    ////////////////////
    // Sequencer FSM
    ////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state       <= SEQ_IDLE;
            o_trig_ack  <= 1'b0;
            o_cmd_rd_en <= 1'b0;
            o_cmd_addr  <= '0;
            op.op_req   <= 1'b0;
        end else begin
            if (o_trig_ack && !i_trig_req) begin
                o_trig_ack <= 1'b0;              // Closes the trigger handshake
            end

            case (state)
                SEQ_IDLE: begin
                    if (i_trig_req && !o_trig_ack) begin
                        o_trig_ack  <= 1'b1;
                        o_cmd_addr  <= i_trig_start;
                        o_cmd_rd_en <= 1'b1;
                        state       <= SEQ_FETCH;
                    end
                end
                SEQ_FETCH: begin
                    if (word_take) begin
                        o_cmd_rd_en <= 1'b0;
                        if (word_zero) begin
                            state <= SEQ_IDLE;
                        end else begin
                            op.op_req <= 1'b1;   // Fields load on the same edge
                            state     <= SEQ_ISSUE;
                        end
                    end
                end
                SEQ_ISSUE: begin
                    if (op.op_ack) begin
                        op.op_req <= 1'b0;
                        state     <= SEQ_WAIT;
                    end
                end
                SEQ_WAIT: begin
                    // Next command only once the executor has released ack
                    if (!op.op_ack) begin
                        o_cmd_addr  <= o_cmd_addr + CMD_ADDR_STEP;
                        o_cmd_rd_en <= 1'b1;
                        state       <= SEQ_FETCH;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // Command decode
    ////////////////////
    always_ff @(posedge i_clk) begin
        if (word_take && !word_zero) begin
            op.op_kind <= opcode_e'(i_cmd_data[OPC_MSB:OPC_LSB]);
            op.op_addr <= {i_cmd_data[CADDR_MSB:CADDR_LSB], 2'b00};  // Word to byte address
            op.op_data <= i_cmd_data[CDATA_MSB:0];
        end
    end

endmodule

/* rtl/gpe_trig_arb.sv */
////////////////////
// GP engine trigger arbiter
// Edge detect and pending latch with lowest-index choice
////////////////////
`timescale 1ns/1ps

module gpe_trig_arb (
    input  logic               i_clk,
    input  logic               i_rstn,
    input  gpe_pkg::trig_vec_t i_trig,
    input  gpe_pkg::trig_vec_t i_trig_en,
    input  gpe_pkg::trig_vec_t i_trig_rise,
    input  gpe_pkg::cmd_addr_t i_trig_start [gpe_pkg::N_TRIG],
    output logic               o_req,
    input  logic               i_ack,
    output gpe_pkg::cmd_addr_t o_start
);
    import gpe_pkg::*;

    trig_vec_t trig_q;                           // Registered trigger inputs
    trig_vec_t trig_prev;                        // Value one cycle earlier
    trig_vec_t rise_det;
    trig_vec_t fall_det;
    trig_vec_t trig_edge;
    trig_vec_t pending;
    trig_vec_t pend_clr;
    trig_idx_t pick;                             // Lowest pending source
    trig_idx_t sel_q;                            // Source now on o_start
    trig_idx_t sel_ack;                          // Source the sequencer took

    ////////////////////
    // Edge detection
    ////////////////////
    assign rise_det  = trig_q & ~trig_prev;
    assign fall_det  = ~trig_q & trig_prev;
    assign trig_edge = i_trig_en & ((i_trig_rise & rise_det) | (~i_trig_rise & fall_det));

    always_comb begin
        pick = '0;
        for (int i = N_TRIG - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick = trig_idx_t'(i);
            end
        end
    end

    always_comb begin
        pend_clr = '0;
        if (o_req && i_ack) begin
            pend_clr[sel_ack] = 1'b1;            // Served source leaves the queue
        end
    end

    ////////////////////
    // Pending and handshake
    ////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            trig_q    <= '0;
            trig_prev <= '0;
            pending   <= '0;
            o_req     <= 1'b0;
            o_start   <= '0;
            sel_q     <= '0;
            sel_ack   <= '0;
        end else begin
            trig_q    <= i_trig;
            trig_prev <= trig_q;
            pending   <= (pending & ~pend_clr) | trig_edge;  // Repeat edges merge

            if (o_req) begin
                if (i_ack) begin
                    o_req <= 1'b0;
                end else begin
                    // Offer stays current while the sequencer is busy
                    sel_ack <= sel_q;
                    sel_q   <= pick;
                    o_start <= i_trig_start[pick];
                end
            end else if (!i_ack && (pending != '0)) begin
                o_req   <= 1'b1;
                sel_q   <= pick;
                o_start <= i_trig_start[pick];
            end
        end
    end

endmodule

/* rtl/gpe_op_if.sv */
////////////////////
// GP engine operation channel
// One decoded bus operation from sequencer to executor
////////////////////
`timescale 1ns/1ps

interface gpe_op_if;
    import gpe_pkg::*;

    logic      op_req;                           // Held until op_ack rises
    opcode_e   op_kind;
    bus_addr_t op_addr;                          // Byte address
    data_t     op_data;                          // Write data or mask
    logic      op_ack;                           // Raised after the last poll read

    modport seq (
        output op_req,
        output op_kind,
        output op_addr,
        output op_data,
        input  op_ack
    );

    modport exec (
        input  op_req,
        input  op_kind,
        input  op_addr,
        input  op_data,
        output op_ack
    );

endinterface

/* rtl/gpe_pkg.sv */
////////////////////
// GP engine shared definitions
// Widths, command fields, opcodes and FSM states
////////////////////
package gpe_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int N_TRIG     = 4;               // Hardware trigger sources
    localparam int TRIG_IDX_W = $clog2(N_TRIG);
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int CMD_W      = 64;
    localparam int CMD_ADDR_W = 8;               // Command buffer depth 256

    ////////////////////
    // Command word layout
    ////////////////////
    localparam int OPC_MSB   = 63;
    localparam int OPC_LSB   = 62;
    localparam int CADDR_MSB = 61;               // Word address of the target
    localparam int CADDR_LSB = 32;
    localparam int CDATA_MSB = 31;               // Write data or mask down to bit 0

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [ADDR_W-1:0]     bus_addr_t;
    typedef logic [CMD_W-1:0]      cmd_word_t;
    typedef logic [CMD_ADDR_W-1:0] cmd_addr_t;
    typedef logic [N_TRIG-1:0]     trig_vec_t;
    typedef logic [TRIG_IDX_W-1:0] trig_idx_t;

    // Each command takes two 32-bit slots in the buffer
    localparam cmd_addr_t CMD_ADDR_STEP = cmd_addr_t'(2);

    typedef enum logic [1:0] {
        OP_WRITE    = 2'd0,                      // Plain or merged write
        OP_RMW_READ = 2'd1,                      // Read and keep unmasked bits
        OP_POLL_SET = 2'd2,                      // Wait for masked bits all one
        OP_POLL_CLR = 2'd3                       // Wait for masked bits all zero
    } opcode_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_FETCH,                               // Command read in flight
        SEQ_ISSUE,                               // Operation offered to executor
        SEQ_WAIT                                 // Waiting for ack to drop
    } seq_state_e;

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_ADDR,                                 // Bus request held until ready
        EX_RDATA,                                // Waiting for read data
        EX_ACK                                   // Done and waiting for req to drop
    } exec_state_e;

endpackage
